// ==== design/eg_pkg.sv ====
package eg_pkg;

    localparam int num_ops   = 8;               // operators per frame
    localparam int op_w      = 3;               // operator index width
    localparam int frame_len = 16;              // cycles per sample frame
    localparam int frame_w   = $clog2(frame_len);

    localparam int env_w  = 9;                  // internal attenuation
    localparam int out_w  = 10;                 // level plus 4*tl
    localparam int addr_w = 5;                  // host address, field + op
    localparam int word_w = 32;                 // one ram word per operator
    localparam int be_w   = 4;                  // byte lanes per word
    localparam int rate_w = 4;
    localparam int tl_w   = 6;

    localparam logic [env_w-1:0] silence = env_w'(511);

    // byte lane of each register field within the operator word
    localparam logic [1:0] fld_level   = 2'd0;  // ksl/tl
    localparam logic [1:0] fld_rate_ad = 2'd1;  // ar hi, dr lo
    localparam logic [1:0] fld_rate_sr = 2'd2;  // sl hi, rr lo
    localparam logic [1:0] fld_ctrl    = 2'd3;  // key_on, egt

    localparam int ctrl_key_on = 0;             // bit in ctrl byte
    localparam int ctrl_egt    = 1;

    // envelope phases, one-hot since they live in the engine memory
    localparam logic [3:0] ph_attack  = 4'b0001;
    localparam logic [3:0] ph_decay   = 4'b0010;
    localparam logic [3:0] ph_sustain = 4'b0100;
    localparam logic [3:0] ph_release = 4'b1000;

    typedef union packed {
        struct packed {
            logic [1:0]      ksl;               // unused by the engine
            logic [tl_w-1:0] tl;                // total level
        } lvl;
        struct packed {
            logic [rate_w-1:0] hi;
            logic [rate_w-1:0] lo;
        } rate;
    } reg_byte_u;

endpackage

// ==== design/host_reg_port.sv ====
`timescale 1ns/1ps

module host_reg_port
    import eg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_stb,           // single cycle, no stall
    input  logic [addr_w-1:0] wr_addr,          // [4:3] field, [2:0] op
    input  logic [7:0]        wr_data,
    output logic              req_stb,
    output logic [op_w-1:0]   req_op,
    output logic [be_w-1:0]   req_be,           // one-hot byte lane
    output logic [word_w-1:0] req_word          // byte copied to all lanes
);

    logic [1:0] fld;
    reg_byte_u  wr_byte;

    assign fld = wr_addr[addr_w-1:op_w];

    always_comb begin
        wr_byte = wr_data;
        if (fld == fld_level) begin
            wr_byte.lvl.ksl = '0;               // no key scaling here
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_stb <= 1'b0;
        end else begin
            req_stb <= wr_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_stb) begin
            req_op   <= wr_addr[op_w-1:0];
            req_be   <= be_w'(1) << fld;        // lane = field code
            req_word <= {be_w{wr_byte}};
        end
    end

endmodule

// ==== design/param_arbiter.sv ====
`timescale 1ns/1ps

module param_arbiter
    import eg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_stb,          // host write request
    input  logic [op_w-1:0]   req_op,
    input  logic [be_w-1:0]   req_be,
    input  logic [word_w-1:0] req_word,
    input  logic              rd_stb,           // engine read, always wins
    input  logic [op_w-1:0]   rd_op,
    output logic [word_w-1:0] rd_word,
    output logic              ram_en,
    output logic              ram_we,
    output logic [be_w-1:0]   ram_be,
    output logic [op_w-1:0]   ram_addr,
    output logic [word_w-1:0] ram_wdata,
    input  logic [word_w-1:0] ram_rdata
);

    logic              pend_vld;                // one-deep write slot
    logic [op_w-1:0]   pend_op;
    logic [be_w-1:0]   pend_be;
    logic [word_w-1:0] pend_word;
    logic              do_write;

    assign do_write  = pend_vld && !rd_stb;     // only in read-free cycles
    assign ram_en    = rd_stb || pend_vld;
    assign ram_we    = do_write;
    assign ram_be    = pend_be;
    assign ram_addr  = rd_stb ? rd_op : pend_op;
    assign ram_wdata = pend_word;
    assign rd_word   = ram_rdata;               // ram already registered

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_vld <= 1'b0;
        end else if (req_stb) begin
            pend_vld <= 1'b1;
        end else if (do_write) begin
            pend_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_stb) begin
            pend_op   <= req_op;
            pend_be   <= req_be;
            pend_word <= req_word;
        end
    end

    // host spacing must let the previous write drain before the next one
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        req_stb |-> !pend_vld);

endmodule

// ==== design/param_ram.sv ====
`timescale 1ns/1ps

module param_ram
    import eg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ram_en,
    input  logic              ram_we,
    input  logic [be_w-1:0]   ram_be,
    input  logic [op_w-1:0]   ram_addr,
    input  logic [word_w-1:0] ram_wdata,
    output logic [word_w-1:0] ram_rdata         // valid one cycle after read
);

    logic [word_w-1:0] mem [num_ops];           // one word per operator

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_ops; i++) begin
                mem[i] <= '0;                   // all params zero
            end
        end else if (ram_en && ram_we) begin
            for (int b = 0; b < be_w; b++) begin
                if (ram_be[b]) begin
                    mem[ram_addr][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
    end

    // read port, holds last data when idle
    always_ff @(posedge clk) begin
        if (ram_en && !ram_we) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// ==== design/op_sequencer.sv ====
`timescale 1ns/1ps

module op_sequencer
    import eg_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    output logic            slot_stb,           // frame cycles 0..7
    output logic [op_w-1:0] slot_op
);

    logic [frame_w-1:0] cnt;                    // wraps every frame

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            slot_stb <= 1'b0;
            slot_op  <= '0;
        end else begin
            cnt      <= cnt + 1'b1;
            slot_stb <= (cnt < num_ops);        // idle for the back half
            slot_op  <= cnt[op_w-1:0];
        end
    end

    a_op_range: assert property (@(posedge clk) disable iff (!arst_n)
        slot_stb |-> slot_op < num_ops);

endmodule

// ==== design/envelope_engine.sv ====
`timescale 1ns/1ps

module envelope_engine
    import eg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              slot_stb,         // p0
    input  logic [op_w-1:0]   slot_op,
    output logic              rd_stb,           // param read issued at p0
    output logic [op_w-1:0]   rd_op,
    input  logic [word_w-1:0] rd_word,          // arrives at p1
    output logic              out_stb,          // p3
    output logic [op_w-1:0]   out_op,
    output logic [out_w-1:0]  out_level
);

    logic [3:0]       phase_mem [num_ops];      // per-operator state
    logic [env_w-1:0] level_mem [num_ops];
    logic             vld_p1, vld_p2;
    logic [op_w-1:0]  op_p1, op_p2;
    reg_byte_u        lvl_b, ad_b, sr_b;        // byte views of rd_word
    logic [3:0]       phase_p2, next_phase;
    logic [env_w-1:0] level_p2, level_pre, step;
    logic [tl_w-1:0]  tl_p2;
    logic [rate_w-1:0] ar_p2, dr_p2, sl_p2, rr_p2, rate;
    logic             key_on_p2, egt_p2;
    logic             restart, eg_off;
    logic [2:0]       shift;                    // 0..4
    logic [4:0]       sl_ext;                   // sl 15 means 31
    logic [env_w+3:0] inv_ext;                  // ones shift in from the top

    assign rd_stb = slot_stb;
    assign rd_op  = slot_op;

    assign lvl_b = rd_word[fld_level*8 +: 8];
    assign ad_b  = rd_word[fld_rate_ad*8 +: 8];
    assign sr_b  = rd_word[fld_rate_sr*8 +: 8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_p1 <= 1'b0;
            vld_p2 <= 1'b0;
        end else begin
            vld_p1 <= slot_stb;
            vld_p2 <= vld_p1;
        end
    end

    // param split and own state lookup into p2
    always_ff @(posedge clk) begin
        op_p1     <= slot_op;
        op_p2     <= op_p1;
        phase_p2  <= phase_mem[op_p1];
        level_p2  <= level_mem[op_p1];
        tl_p2     <= lvl_b.lvl.tl;
        ar_p2     <= ad_b.rate.hi;
        dr_p2     <= ad_b.rate.lo;
        sl_p2     <= sr_b.rate.hi;
        rr_p2     <= sr_b.rate.lo;
        key_on_p2 <= rd_word[fld_ctrl*8 + ctrl_key_on];
        egt_p2    <= rd_word[fld_ctrl*8 + ctrl_egt];
    end

    always_comb begin
        restart = key_on_p2 && (phase_p2 == ph_release);
        rate    = '0;
        if (restart) begin
            rate = ar_p2;                       // retrigger from release
        end else begin
            case (phase_p2)
                ph_attack:  rate = ar_p2;
                ph_decay:   rate = dr_p2;
                ph_sustain: rate = egt_p2 ? '0 : rr_p2;  // egt holds level
                default:    rate = rr_p2;
            endcase
        end
        shift      = (rate == '0) ? 3'd0 : 3'(({1'b0, rate} + 5'd3) >> 2);
        eg_off     = &level_p2[env_w-1:3];
        sl_ext     = (sl_p2 == 4'hf) ? 5'h1f : {1'b0, sl_p2};
        inv_ext    = ~{4'b0, level_p2};
        level_pre  = level_p2;
        step       = '0;
        next_phase = phase_p2;
        if (restart && rate == 4'hf) begin
            level_pre = '0;                     // instant attack
        end
        if (eg_off && phase_p2 != ph_attack && !restart) begin
            level_pre = silence;
        end
        case (phase_p2)
            ph_attack: begin
                if (level_p2 == '0) begin
                    next_phase = ph_decay;
                end else if (key_on_p2 && shift != 0 && rate != 4'hf) begin
                    step = env_w'(inv_ext >> (3'd4 - shift));
                end
            end
            ph_decay: begin
                if (level_p2[env_w-1:4] == sl_ext) begin
                    next_phase = ph_sustain;
                end else if (!eg_off && !restart && shift != 0) begin
                    step = env_w'(1) << (shift - 3'd1);
                end
            end
            default: begin                      // sustain and release
                if (!eg_off && !restart && shift != 0) begin
                    step = env_w'(1) << (shift - 3'd1);
                end
            end
        endcase
        if (restart) begin
            next_phase = ph_attack;
        end
        if (!key_on_p2) begin
            next_phase = ph_release;
        end
    end

    // write back at the p2/p3 edge, well before the next frame reads it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_ops; i++) begin
                phase_mem[i] <= ph_release;
                level_mem[i] <= silence;
            end
        end else if (vld_p2) begin
            phase_mem[op_p2] <= next_phase;
            level_mem[op_p2] <= level_pre + step;  // wraps mod 512
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_stb <= 1'b0;
        end else begin
            out_stb <= vld_p2;
        end
    end

    always_ff @(posedge clk) begin
        out_op    <= op_p2;
        out_level <= {1'b0, level_p2} + {2'b0, tl_p2, 2'b00};  // pre-update level
    end

    a_phase_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        vld_p2 |-> $onehot(phase_p2));

endmodule

// ==== design/eg_top.sv ====
`timescale 1ns/1ps

module eg_top
    import eg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_stb,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [7:0]        wr_data,
    output logic              out_stb,
    output logic [op_w-1:0]   out_op,
    output logic [out_w-1:0]  out_level
);

    logic              slot_stb;
    logic [op_w-1:0]   slot_op;
    logic              req_stb;                 // host port to arbiter
    logic [op_w-1:0]   req_op;
    logic [be_w-1:0]   req_be;
    logic [word_w-1:0] req_word;
    logic              rd_stb;                  // engine to arbiter
    logic [op_w-1:0]   rd_op;
    logic [word_w-1:0] rd_word;
    logic              ram_en, ram_we;          // single ram port
    logic [be_w-1:0]   ram_be;
    logic [op_w-1:0]   ram_addr;
    logic [word_w-1:0] ram_wdata, ram_rdata;

    op_sequencer seq_i (.clk, .arst_n, .slot_stb, .slot_op);

    host_reg_port host_i (
        .clk, .arst_n, .wr_stb, .wr_addr, .wr_data,
        .req_stb, .req_op, .req_be, .req_word
    );

    param_arbiter arb_i (
        .clk, .arst_n, .req_stb, .req_op, .req_be, .req_word,
        .rd_stb, .rd_op, .rd_word,
        .ram_en, .ram_we, .ram_be, .ram_addr, .ram_wdata, .ram_rdata
    );

    param_ram ram_i (
        .clk, .arst_n, .ram_en, .ram_we, .ram_be, .ram_addr, .ram_wdata, .ram_rdata
    );

    envelope_engine eng_i (
        .clk, .arst_n, .slot_stb, .slot_op, .rd_stb, .rd_op, .rd_word,
        .out_stb, .out_op, .out_level
    );

endmodule

// ==== verification/tb_eg_model.svh ====
`ifndef TB_EG_MODEL_SVH
`define TB_EG_MODEL_SVH

logic [7:0] m_reg [num_ops][4];                 // register bytes by field code
logic [3:0] m_phase [num_ops];
int         m_level [num_ops];

function automatic void clear_model();
    for (int i = 0; i < num_ops; i++) begin
        for (int f = 0; f < 4; f++) begin
            m_reg[i][f] = 8'h00;
        end
        m_phase[i] = ph_release;                // keyed off and silent
        m_level[i] = silence;
    end
endfunction

function automatic void store_register(int op, int fld, logic [7:0] data);
    m_reg[op][fld] = (fld == fld_level) ? (data & 8'h3f) : data;  // ksl dropped
endfunction

// one envelope update for one operator that returns the output level
function automatic int advance_envelope(int op);
    logic [3:0] ph;
    logic [3:0] np;
    logic       key;
    logic       egt;
    logic       rst;
    logic       off;
    int         lv;
    int         nl;
    int         inc;
    int         r;
    int         sh;
    int         sl;
    ph  = m_phase[op];
    lv  = m_level[op];
    key = m_reg[op][fld_ctrl][0];
    egt = m_reg[op][fld_ctrl][1];
    rst = key && ph == ph_release;              // retrigger
    if (rst || ph == ph_attack) begin
        r = m_reg[op][fld_rate_ad][7:4];
    end else if (ph == ph_decay) begin
        r = m_reg[op][fld_rate_ad][3:0];
    end else if (ph == ph_sustain && egt) begin
        r = 0;                                  // held
    end else begin
        r = m_reg[op][fld_rate_sr][3:0];
    end
    sh  = (r == 0) ? 0 : (r + 3) / 4;
    sl  = (m_reg[op][fld_rate_sr][7:4] == 15) ? 31 : m_reg[op][fld_rate_sr][7:4];
    off = (lv >> 3) == 63;                      // top six bits set
    nl  = lv;
    np  = ph;
    inc = 0;
    if (rst && r == 15) begin
        nl = 0;
    end else if (off && ph != ph_attack && !rst) begin
        nl = silence;
    end
    if (ph == ph_attack) begin
        if (lv == 0) begin
            np = ph_decay;
        end else if (key && sh != 0 && r != 15) begin
            nl = lv - (lv >> (4 - sh)) - 1;     // same as adding the ones-filled inverse
        end
    end else if (ph == ph_decay && (lv >> 4) == sl) begin
        np = ph_sustain;
    end else if (!off && !rst && sh != 0) begin
        inc = 1 << (sh - 1);
    end
    if (rst) begin
        np = ph_attack;
    end
    if (!key) begin
        np = ph_release;
    end
    m_phase[op] = np;
    m_level[op] = (nl + inc) & 511;             // 9-bit wrap
    return lv + 4 * m_reg[op][fld_level];
endfunction

`endif

// ==== verification/tb_eg_top.sv ====
`timescale 1ns/1ps

module tb_eg_top
    import eg_pkg::*;
();

    typedef struct packed {
        logic [op_w-1:0] op;
        logic [1:0]      fld;
        logic [7:0]      data;
        logic            rnd;                   // data from the lcg instead
        logic [7:0]      frames;                // frames until the next write
    } step_t;

    logic              clk;
    logic              arst_n;
    logic              wr_stb;
    logic [addr_w-1:0] wr_addr;
    logic [7:0]        wr_data;
    logic              out_stb;
    logic [op_w-1:0]   out_op;
    logic [out_w-1:0]  out_level;

    step_t       steps [$];
    int          cyc = -1;                      // cycles since reset release
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] rng = 32'h360fea07;

    `include "tb_eg_model.svh"

    eg_top dut_i (.clk, .arst_n, .wr_stb, .wr_addr, .wr_data, .out_stb, .out_op, .out_level);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= -1;
        end else begin
            cyc <= cyc + 1;                     // cycle 0 carries op 0 slot
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void add_step(int op, logic [1:0] fld, logic [7:0] data,
                                     logic rnd, int frames);
        step_t s;
        s.op     = op_w'(op);
        s.fld    = fld;
        s.data   = data;
        s.rnd    = rnd;
        s.frames = 8'(frames);
        steps.push_back(s);
    endfunction

    function automatic void load_table();
        add_step(3, fld_level,   8'he5, 1'b0, 2);   // tl 37 on a silent op
        add_step(1, fld_rate_ad, 8'h88, 1'b0, 1);   // ar 8, dr 8
        add_step(1, fld_rate_sr, 8'h2c, 1'b0, 1);   // sl 2, rr 12
        add_step(1, fld_ctrl,    8'h03, 1'b0, 44);  // attack, decay, held sustain
        add_step(2, fld_rate_ad, 8'hf0, 1'b0, 1);
        add_step(2, fld_ctrl,    8'h01, 1'b0, 3);   // instant attack
        add_step(1, fld_rate_sr, 8'h2f, 1'b0, 1);
        add_step(1, fld_ctrl,    8'h01, 1'b0, 62);  // egt off so sustain runs to silence
        add_step(2, fld_ctrl,    8'h00, 1'b0, 1);   // key off
        add_step(2, fld_rate_sr, 8'h0f, 1'b0, 66);  // release at rr 15
        add_step(2, fld_level,   8'h4a, 1'b0, 2);
        add_step(4, fld_rate_ad, 8'h00, 1'b1, 1);   // one write per frame from here
        add_step(5, fld_rate_sr, 8'h00, 1'b1, 1);
        add_step(6, fld_level,   8'h00, 1'b1, 1);
        add_step(7, fld_rate_ad, 8'h00, 1'b1, 1);
        add_step(4, fld_ctrl,    8'h01, 1'b0, 1);
        add_step(5, fld_rate_ad, 8'h00, 1'b1, 1);
        add_step(5, fld_ctrl,    8'h00, 1'b1, 1);
        add_step(6, fld_rate_sr, 8'h00, 1'b1, 1);
        add_step(7, fld_ctrl,    8'h03, 1'b0, 1);
        add_step(0, fld_level,   8'h3f, 1'b0, 1);
        add_step(4, fld_level,   8'h00, 1'b1, 1);
        add_step(7, fld_rate_sr, 8'h00, 1'b1, 24);
    endfunction

    function automatic int total_frames();
        int sum;
        sum = 0;
        foreach (steps[i]) begin
            sum += steps[i].frames;
        end
        return sum;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_frame_cycle(input int fc);
        do begin
            next_cycle();
        end while (cyc < 0 || cyc % frame_len != fc);
    endtask

    task automatic host_write(input logic [op_w-1:0] op, input logic [1:0] fld,
                              input logic [7:0] data);
        wr_addr = {fld, op};
        wr_data = data;
        wr_stb  = 1'b1;
        store_register(op, fld, data);          // seen from the next sweep on
        next_cycle();
        wr_stb  = 1'b0;
    endtask

    initial begin
        logic [7:0] data;
        wr_stb  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        arst_n  = 1'b0;
        load_table();
        clear_model();
        limit = total_frames() * frame_len + 64;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;
        foreach (steps[i]) begin
            wait_frame_cycle(11);               // past the last output of the frame
            if (steps[i].rnd) begin
                rng  = lcg_next(rng);
                data = rng[23:16];
            end else begin
                data = steps[i].data;
            end
            host_write(steps[i].op, steps[i].fld, data);
            repeat ((steps[i].frames - 1) * frame_len) next_cycle();
        end
        wait_frame_cycle(11);
        $display("SIMULATION PASSED");
        $finish;
    end

    // sampled on the falling edge while outputs are stable
    always @(negedge clk) begin
        int fc;
        int exp_level;
        if (cyc < 0) begin
            assert (out_stb == 1'b0)
                else report_error($sformatf("MISMATCH %0t: out_stb high in reset", $time));
        end else begin
            fc = cyc % frame_len;
            assert (out_stb == (fc >= 3 && fc < 3 + num_ops))
                else report_error($sformatf("MISMATCH %0t: out_stb %0b in frame cycle %0d",
                                            $time, out_stb, fc));
            if (out_stb) begin
                assert (out_op == op_w'(fc - 3))
                    else report_error($sformatf("MISMATCH %0t: out_op %0d, expected %0d",
                                                $time, out_op, fc - 3));
                exp_level = advance_envelope(fc - 3);
                assert (out_level == out_w'(exp_level))
                    else report_error($sformatf("MISMATCH %0t: op %0d level %0d, expected %0d",
                                                $time, out_op, out_level, exp_level));
            end
        end
    end

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            report_error($sformatf("timeout: no verdict after %0d cycles", cycles));
        end
    end

endmodule

// ==== flist.f ====
+incdir+verification
design/eg_pkg.sv
design/host_reg_port.sv
design/param_arbiter.sv
design/param_ram.sv
design/op_sequencer.sv
design/envelope_engine.sv
design/eg_top.sv
verification/tb_eg_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_eg_top with Verilator, verdict taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_eg_top -f flist.f \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_eg_top > sim.log 2>&1
cat sim.log
[ -s sim.log ] && ! grep -q "SIMULATION FAILED" sim.log && exit 0 || exit 1
